// File: design/cpu.sv
`timescale 1ns/1ps

module cpu
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            rdy_in,        // low pauses the whole core
    input  logic [7:0]      mem_din_i,
    output logic [7:0]      mem_dout_o,
    output logic [XLEN-1:0] mem_a_o,       // byte address, io above 0x30000
    output logic            mem_wr_o,
    output logic [XLEN-1:0] dbgreg_dout_o  // x10
);

    logic            if_req;
    mem_req_t        if_cmd;
    logic            if_ack;
    logic            rt_req;
    mem_req_t        rt_cmd;
    logic            rt_ack;
    logic [XLEN-1:0] mem_rdata;

    logic            inst_req;
    inst_pkt_t       inst_pkt;
    logic            inst_ack;
    logic [XLEN-1:0] next_pc;

    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;

    logic            ret_req;
    retire_pkt_t     ret_pkt;
    logic            ret_ack;

    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [XLEN-1:0] wr_data;

    mem_ctrl mem_ctrl_(
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_in(rdy_in),
        .if_req_i(if_req), .if_cmd_i(if_cmd), .if_ack_o(if_ack),
        .rt_req_i(rt_req), .rt_cmd_i(rt_cmd), .rt_ack_o(rt_ack),
        .rdata_o(mem_rdata),
        .mem_din_i(mem_din_i), .mem_dout_o(mem_dout_o), .mem_a_o(mem_a_o), .mem_wr_o(mem_wr_o)
    );

    fetch_unit fetch_unit_(
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_in(rdy_in),
        .mem_req_o(if_req), .mem_cmd_o(if_cmd), .mem_ack_i(if_ack), .mem_rdata_i(mem_rdata),
        .inst_req_o(inst_req), .inst_o(inst_pkt), .inst_ack_i(inst_ack), .next_pc_i(next_pc)
    );

    exec_unit exec_unit_(
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_in(rdy_in),
        .inst_req_i(inst_req), .inst_i(inst_pkt), .inst_ack_o(inst_ack), .next_pc_o(next_pc),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ret_req_o(ret_req), .ret_o(ret_pkt), .ret_ack_i(ret_ack)
    );

    retire_unit retire_unit_(
        .clk_in(clk_in), .rst_n_i(rst_n_i), .rdy_in(rdy_in),
        .ret_req_i(ret_req), .ret_i(ret_pkt), .ret_ack_o(ret_ack),
        .mem_req_o(rt_req), .mem_cmd_o(rt_cmd), .mem_ack_i(rt_ack), .mem_rdata_i(mem_rdata),
        .wr_en_o(wr_en), .wr_addr_o(wr_addr), .wr_data_o(wr_data)
    );

    reg_file reg_file_(
        .clk_in(clk_in), .rst_n_i(rst_n_i),
        .wr_en_i(wr_en), .wr_addr_i(wr_addr), .wr_data_i(wr_data),
        .rs1_addr_i(rs1_addr), .rs1_data_o(rs1_data),
        .rs2_addr_i(rs2_addr), .rs2_data_o(rs2_data),
        .dbg_o(dbgreg_dout_o)
    );

endmodule

// File: design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            rdy_in,
    input  logic            inst_req_i,
    input  inst_pkt_t       inst_i,
    output logic            inst_ack_o,
    output logic [XLEN-1:0] next_pc_o,
    output logic [4:0]      rs1_addr_o,
    output logic [4:0]      rs2_addr_o,
    input  logic [XLEN-1:0] rs1_data_i,
    input  logic [XLEN-1:0] rs2_data_i,
    output logic            ret_req_o,
    output retire_pkt_t     ret_o,
    input  logic            ret_ack_i
);

    typedef enum logic [1:0] {EX_IDLE, EX_RET, EX_RDROP, EX_ACK} ex_state_e;

    ex_state_e       state_q;
    logic [XLEN-1:0] ir;
    opcode_e         opcode;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] pc_plus4;
    logic            taken;
    alu_op_e         alu_op;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    kind_e           kind;
    retire_pkt_t     ret_d;
    logic [XLEN-1:0] next_pc_d;
    retire_pkt_t     ret_q;
    logic [XLEN-1:0] next_pc_q;

    assign ir         = inst_i.inst;
    assign opcode     = opcode_e'(ir[6:0]);
    assign rs1_addr_o = ir[19:15];
    assign rs2_addr_o = ir[24:20];

    assign imm_i = {{20{ir[31]}}, ir[31:20]};
    assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
    assign imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'd0};
    assign imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};

    assign pc_plus4 = inst_i.pc + 32'd4;
    assign taken    = (rs1_data_i == rs2_data_i) ^ ir[12]; // funct3 bit 0 selects bne

    always_comb begin
        alu_op    = ALU_ADD;
        op_b      = imm_i;
        kind      = K_NONE;
        next_pc_d = pc_plus4;
        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                if (opcode == OPC_OP) op_b = rs2_data_i;
                case (ir[14:12])
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: alu_op = (opcode == OPC_OP && ir[30]) ? ALU_SUB : ALU_ADD;
                endcase
                kind = K_REG;
            end
            OPC_LUI: begin
                alu_op = ALU_PASS_B;
                op_b   = imm_u;
                kind   = K_REG;
            end
            OPC_LOAD: kind = K_LOAD;
            OPC_STORE: begin
                op_b = imm_s;
                kind = (ir[14:12] == 3'b000) ? K_STORE_B : K_STORE_W;
            end
            OPC_JAL: begin
                kind      = K_REG; // link goes through the normal write
                next_pc_d = inst_i.pc + imm_j;
            end
            OPC_BRANCH: if (taken) next_pc_d = inst_i.pc + imm_b;
            default: ;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_data_i + op_b;
        endcase
    end

    assign ret_d = '{kind:   kind,
                     rd:     ir[11:7],
                     result: (opcode == OPC_JAL) ? pc_plus4 : alu_res,
                     sdata:  rs2_data_i};

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EX_IDLE;
        end else if (rdy_in) begin
            case (state_q)
                EX_IDLE:  if (inst_req_i) state_q <= EX_RET;
                EX_RET:   if (ret_ack_i) state_q <= EX_RDROP;
                EX_RDROP: if (!ret_ack_i) state_q <= EX_ACK; // retire fully closed
                EX_ACK:   if (!inst_req_i) state_q <= EX_IDLE;
                default:  state_q <= EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && state_q == EX_IDLE && inst_req_i) begin
            ret_q     <= ret_d;
            next_pc_q <= next_pc_d;
        end
    end

    assign ret_req_o  = (state_q == EX_RET);
    assign ret_o      = ret_q;
    assign inst_ack_o = (state_q == EX_ACK);
    assign next_pc_o  = next_pc_q;

endmodule

// File: design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            rdy_in,
    output logic            mem_req_o,
    output mem_req_t        mem_cmd_o,
    input  logic            mem_ack_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output logic            inst_req_o,
    output inst_pkt_t       inst_o,
    input  logic            inst_ack_i,
    input  logic [XLEN-1:0] next_pc_i
);

    typedef enum logic [1:0] {F_MEM, F_MDROP, F_INST, F_IDROP} fetch_state_e;

    fetch_state_e    state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] inst_q;

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= F_IDROP; // leaves on the first active cycle
            pc_q    <= RESET_PC;
        end else if (rdy_in) begin
            case (state_q)
                F_MEM:   if (mem_ack_i) state_q <= F_MDROP;
                F_MDROP: if (!mem_ack_i) state_q <= F_INST;
                F_INST: begin
                    if (inst_ack_i) begin
                        pc_q    <= next_pc_i; // valid while ack is high
                        state_q <= F_IDROP;
                    end
                end
                F_IDROP: if (!inst_ack_i) state_q <= F_MEM;
                default: state_q <= F_IDROP;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && state_q == F_MEM && mem_ack_i) inst_q <= mem_rdata_i;
    end

    assign mem_req_o  = (state_q == F_MEM);
    assign mem_cmd_o  = '{wr: 1'b0, byte_len: 1'b0, addr: pc_q, wdata: '0};
    assign inst_req_o = (state_q == F_INST);
    assign inst_o     = '{pc: pc_q, inst: inst_q};

    inst_stable: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        inst_req_o |=> !inst_req_o || $stable(inst_o));

endmodule

// File: design/mem_ctrl.sv
`timescale 1ns/1ps

module mem_ctrl
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            rdy_in,
    input  logic            if_req_i,
    input  mem_req_t        if_cmd_i,
    output logic            if_ack_o,
    input  logic            rt_req_i,
    input  mem_req_t        rt_cmd_i,
    output logic            rt_ack_o,
    output logic [XLEN-1:0] rdata_o,
    input  logic [7:0]      mem_din_i,
    output logic [7:0]      mem_dout_o,
    output logic [XLEN-1:0] mem_a_o,
    output logic            mem_wr_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_ACK} mc_state_e;

    mc_state_e       state_q;
    logic            sel_rt_q;  // retire side owns the current access
    mem_req_t        cmd_q;
    mem_req_t        req_cmd;
    logic [1:0]      cnt_q;     // byte index on the address bus
    logic [1:0]      last_byte;
    logic            bus_vld_q; // mem_din_i carries the byte at bus_idx_q
    logic [1:0]      bus_idx_q;
    logic [XLEN-1:0] data_q;

    assign req_cmd   = rt_req_i ? rt_cmd_i : if_cmd_i; // retire wins
    assign last_byte = cmd_q.byte_len ? 2'd0 : 2'd3;

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= ST_IDLE;
            sel_rt_q <= 1'b0;
            cmd_q    <= '0;
            cnt_q    <= 2'd0;
        end else if (rdy_in) begin
            case (state_q)
                ST_IDLE: begin
                    if (rt_req_i || if_req_i) begin
                        sel_rt_q <= rt_req_i;
                        cmd_q    <= req_cmd;
                        cnt_q    <= 2'd0;
                        state_q  <= req_cmd.wr ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    if (cnt_q != 2'd3) cnt_q <= cnt_q + 2'd1;
                    if (bus_vld_q && bus_idx_q == 2'd3) state_q <= ST_ACK; // top byte lands now
                end
                ST_WRITE: begin
                    if (cnt_q == last_byte) state_q <= ST_ACK;
                    else cnt_q <= cnt_q + 2'd1;
                end
                ST_ACK: begin
                    if (!(sel_rt_q ? rt_req_i : if_req_i)) state_q <= ST_IDLE;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // read data shows up one cycle after its address, paused or not
    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus_vld_q <= 1'b0;
            bus_idx_q <= 2'd0;
        end else begin
            bus_vld_q <= (state_q == ST_READ);
            bus_idx_q <= cnt_q;
        end
    end

    always_ff @(posedge clk_in) begin
        if (bus_vld_q) begin
            data_q[bus_idx_q*8 +: 8] <= mem_din_i; // little endian lanes
        end else if (rdy_in && state_q == ST_IDLE) begin
            data_q <= req_cmd.wdata;
        end else if (rdy_in && state_q == ST_WRITE) begin
            data_q <= data_q >> 8; // next byte to the low lane
        end
    end

    assign mem_a_o    = cmd_q.addr + {30'd0, cnt_q};
    assign mem_dout_o = data_q[7:0];
    assign mem_wr_o   = (state_q == ST_WRITE) && rdy_in;
    assign rdata_o    = data_q;
    assign if_ack_o   = (state_q == ST_ACK) && !sel_rt_q;
    assign rt_ack_o   = (state_q == ST_ACK) && sel_rt_q;

    // an ack only comes up while its owner still holds req
    ack_needs_req: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        $rose(if_ack_o || rt_ack_o) |-> (sel_rt_q ? rt_req_i : if_req_i));

    // a paused cycle writes nothing and leaves the bus address in place
    pause_freeze: assert property (@(posedge clk_in) disable iff (!rst_n_i)
        !rdy_in |-> !mem_wr_o ##1 $stable(mem_a_o));

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            wr_en_i,
    input  logic [4:0]      wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i,
    input  logic [4:0]      rs1_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs2_data_o,
    output logic [XLEN-1:0] dbg_o
);

    logic [XLEN-1:0] regs_q [32];

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != 5'd0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];
    assign dbg_o      = regs_q[10]; // a0

endmodule

// File: design/retire_unit.sv
`timescale 1ns/1ps

module retire_unit
    import rv_pkg::*;
(
    input  logic            clk_in,
    input  logic            rst_n_i,
    input  logic            rdy_in,
    input  logic            ret_req_i,
    input  retire_pkt_t     ret_i,
    output logic            ret_ack_o,
    output logic            mem_req_o,
    output mem_req_t        mem_cmd_o,
    input  logic            mem_ack_i,
    input  logic [XLEN-1:0] mem_rdata_i,
    output logic            wr_en_o,
    output logic [4:0]      wr_addr_o,
    output logic [XLEN-1:0] wr_data_o
);

    typedef enum logic [1:0] {RT_IDLE, RT_MEM, RT_MDROP, RT_ACK} rt_state_e;

    rt_state_e       state_q;
    logic            wr_en_q;
    logic [4:0]      wr_addr_q;
    logic [XLEN-1:0] wr_data_q;

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= RT_IDLE;
            wr_en_q <= 1'b0;
        end else if (rdy_in) begin
            wr_en_q <= 1'b0; // one cycle strobe
            case (state_q)
                RT_IDLE: begin
                    if (ret_req_i) begin
                        case (ret_i.kind)
                            K_REG: begin
                                wr_en_q <= 1'b1;
                                state_q <= RT_ACK;
                            end
                            K_LOAD, K_STORE_W, K_STORE_B: state_q <= RT_MEM;
                            default: state_q <= RT_ACK; // plain branch
                        endcase
                    end
                end
                RT_MEM: begin
                    if (mem_ack_i) begin
                        wr_en_q <= (ret_i.kind == K_LOAD);
                        state_q <= RT_MDROP;
                    end
                end
                RT_MDROP: if (!mem_ack_i) state_q <= RT_ACK;
                RT_ACK:   if (!ret_req_i) state_q <= RT_IDLE;
                default:  state_q <= RT_IDLE;
            endcase
        end
    end

    // load word is only valid while mem_ack_i is high
    always_ff @(posedge clk_in) begin
        if (rdy_in) begin
            wr_addr_q <= ret_i.rd;
            wr_data_q <= (state_q == RT_MEM) ? mem_rdata_i : ret_i.result;
        end
    end

    assign mem_req_o = (state_q == RT_MEM);
    assign mem_cmd_o = '{wr:       ret_i.kind != K_LOAD,
                         byte_len: ret_i.kind == K_STORE_B,
                         addr:     ret_i.result,
                         wdata:    ret_i.sdata};
    assign ret_ack_o = (state_q == RT_ACK);
    assign wr_en_o   = wr_en_q;
    assign wr_addr_o = wr_addr_q;
    assign wr_data_o = wr_data_q;

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [XLEN-1:0] IO_BASE  = 32'h0003_0000; // console byte out
    localparam logic [XLEN-1:0] IO_STOP  = 32'h0003_0004; // any write ends the program

    // major opcode field, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B // lui
    } alu_op_e;

    // what the retire side has to do with a finished instruction
    typedef enum logic [2:0] {
        K_REG,
        K_LOAD,
        K_STORE_W,
        K_STORE_B,
        K_NONE
    } kind_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } inst_pkt_t;

    typedef struct packed {
        kind_e           kind;
        logic [4:0]      rd;
        logic [XLEN-1:0] result; // alu value, link address or memory address
        logic [XLEN-1:0] sdata;  // store data
    } retire_pkt_t;

    typedef struct packed {
        logic            wr;
        logic            byte_len; // one byte instead of a full word
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f verilog.f

output="$(./obj_dir/Vtb_cpu)"
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// File: verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    logic        clk;
    logic        rst_n;
    logic        rdy;
    logic        pause_en;
    logic        clear;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbg;
    logic        stop;

    logic [31:0] prog [$];
    logic [7:0]  expected [$];
    logic [7:0]  first_run [$];
    logic [31:0] exp_sum;
    logic [31:0] mem_word;
    int          errors;

    cpu UUT(
        .clk_in(clk), .rst_n_i(rst_n), .rdy_in(rdy),
        .mem_din_i(mem_din), .mem_dout_o(mem_dout), .mem_a_o(mem_a),
        .mem_wr_o(mem_wr), .dbgreg_dout_o(dbg)
    );

    tb_memory mem_model(
        .clk_i(clk), .clear_i(clear), .mem_wr_i(mem_wr), .mem_a_i(mem_a),
        .wdata_i(mem_dout), .rdata_o(mem_din), .stop_o(stop)
    );

    always #10 clk = ~clk;

    // about one cycle in four is paused when enabled
    always @(posedge clk) begin
        rdy <= pause_en ? ($urandom % 4 != 0) : 1'b1;
    end

    no_write_in_pause: assert property (@(posedge clk) disable iff (!rst_n)
        !rdy |-> !mem_wr)
    else begin
        errors++;
        $display("** Error mem_wr_o: got 0x1 expected 0x0 during a pause");
    end

    addr_held_in_pause: assert property (@(posedge clk) disable iff (!rst_n)
        !rdy |=> $stable(mem_a))
    else begin
        errors++;
        $display("** Error mem_a_o: 0x%h moved during a pause", mem_a);
    end

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else begin
            errors++;
            $display("** Error %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] lui(int rd, int imm20);
        logic [31:0] d;
        logic [31:0] u;
        d = rd;
        u = imm20;
        return {u[19:0], d[4:0], 7'b0110111};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] m;
        d = rd;
        s = rs1;
        m = imm;
        return {m[11:0], s[4:0], 3'b000, d[4:0], 7'b0010011};
    endfunction

    function automatic logic [31:0] lw(int rd, int rs1, int imm);
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] m;
        d = rd;
        s = rs1;
        m = imm;
        return {m[11:0], s[4:0], 3'b010, d[4:0], 7'b0000011};
    endfunction

    function automatic logic [31:0] reg_op(int f7, int f3, int rd, int rs1, int rs2);
        logic [31:0] f;
        logic [31:0] g;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] t;
        f = f7;
        g = f3;
        d = rd;
        s = rs1;
        t = rs2;
        return {f[6:0], t[4:0], s[4:0], g[2:0], d[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] store(int f3, int rs2, int rs1, int imm);
        logic [31:0] g;
        logic [31:0] t;
        logic [31:0] s;
        logic [31:0] m;
        g = f3;
        t = rs2;
        s = rs1;
        m = imm;
        return {m[11:5], t[4:0], s[4:0], g[2:0], m[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(int f3, int rs1, int rs2, int off);
        logic [31:0] g;
        logic [31:0] s;
        logic [31:0] t;
        logic [31:0] o;
        g = f3;
        s = rs1;
        t = rs2;
        o = off;
        return {o[12], o[10:5], t[4:0], s[4:0], g[2:0], o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(int rd, int off);
        logic [31:0] d;
        logic [31:0] o;
        d = rd;
        o = off;
        return {o[20], o[10:1], o[11], o[19:12], d[4:0], 7'b1101111};
    endfunction

    // x5 holds the console address, x10 the running byte sum
    task automatic emit_out(int rd, int value);
        logic [31:0] v;
        v = value;
        prog.push_back(store(0, rd, 5, 0));
        prog.push_back(reg_op(0, 0, 10, 10, rd));
        expected.push_back(v[7:0]);
        exp_sum = exp_sum + v;
    endtask

    task automatic build_program();
        int jal_pc;
        prog.delete();
        expected.delete();
        exp_sum  = 32'd0;
        mem_word = 32'hA1B2_C000 + 32'h0000_03D4;
        prog.push_back(lui(5, 'h30));
        prog.push_back(addi(10, 0, 0));
        prog.push_back(addi(1, 0, 25));
        prog.push_back(addi(2, 0, 17));
        prog.push_back(addi(4, 0, 'hEE));  // marker that must never print
        prog.push_back(addi(12, 0, 'h11));
        prog.push_back(reg_op(0, 0, 3, 1, 2));
        emit_out(3, 25 + 17);
        prog.push_back(reg_op(32, 0, 3, 1, 2));
        emit_out(3, 25 - 17);
        prog.push_back(reg_op(0, 7, 3, 1, 2));
        emit_out(3, 25 & 17);
        prog.push_back(reg_op(0, 6, 3, 1, 2));
        emit_out(3, 25 | 17);
        prog.push_back(reg_op(0, 4, 3, 1, 2));
        emit_out(3, 25 ^ 17);
        prog.push_back(lui(6, 'h12345));
        prog.push_back(addi(6, 6, 'h67));
        prog.push_back(lui(7, 'h12345));
        prog.push_back(reg_op(32, 0, 3, 6, 7));
        emit_out(3, (32'h1234_5000 + 32'h67) - 32'h1234_5000);
        // word round trip, each byte read back and masked down to the low lane
        prog.push_back(lui(8, 'hA1B2C));
        prog.push_back(addi(8, 8, 'h3D4));
        prog.push_back(store(2, 8, 0, 'h100));
        prog.push_back(addi(13, 0, 'hFF));
        for (int k = 0; k < 4; k++) begin
            prog.push_back(lw(9, 0, 'h100 + k));
            prog.push_back(reg_op(0, 7, 3, 9, 13));
            emit_out(3, int'((mem_word >> (8 * k)) & 32'hFF));
        end
        prog.push_back(branch(0, 1, 1, 8));   // beq taken
        prog.push_back(store(0, 4, 5, 0));
        prog.push_back(branch(1, 1, 2, 8));   // bne taken
        prog.push_back(store(0, 4, 5, 0));
        jal_pc = prog.size() * 4;
        prog.push_back(jal(11, 8));
        prog.push_back(store(0, 4, 5, 0));
        prog.push_back(branch(0, 1, 2, 8));   // beq not taken, lands on the sb
        emit_out(12, 'h11);
        emit_out(11, jal_pc + 4);
        prog.push_back(store(2, 0, 5, 4));    // program end
        prog.push_back(jal(0, 0));
    endtask

    task automatic load_memory();
        for (int a = 0; a < 131072; a++) begin
            mem_model.mem[a] = 8'(a ^ (a >> 8) ^ (a >> 16) ^ 7);
        end
        for (int i = 0; i < prog.size(); i++) begin
            for (int b = 0; b < 4; b++) begin
                mem_model.mem[4 * i + b] = prog[i][8 * b +: 8];
            end
        end
    endtask

    task automatic run_program(input logic paused);
        int  n;
        logic seen;
        pause_en <= 1'b0;
        rst_n    <= 1'b0;
        clear    <= 1'b1;
        load_memory();
        repeat (2) @(posedge clk);
        check_hex("mem_wr_o", {31'd0, mem_wr}, 32'd0);
        check_hex("dbgreg_dout_o", dbg, 32'd0);
        clear    <= 1'b0;
        rst_n    <= 1'b1;
        pause_en <= paused;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 3) begin
            @(posedge clk);
            n++;
            if (mem_a == 32'd0 && !mem_wr) seen = 1'b1;
        end
        check_hex("first fetch mem_a_o", seen ? 32'd0 : mem_a, 32'd0);
        n = 0;
        while (!stop && n < 20000) begin
            @(posedge clk);
            n++;
        end
        if (!stop) begin
            errors++;
            $display("timeout: the program never wrote the stop address");
        end
        check_hex("dbgreg_dout_o", dbg, exp_sum);
        for (int b = 0; b < 4; b++) begin
            check_hex("mem[0x100+b]", {24'd0, mem_model.mem[32'h100 + b]},
                      {24'd0, mem_word[8 * b +: 8]});
        end
    endtask

    task automatic check_console(input logic [7:0] ref_q [$]);
        check_hex("console length", mem_model.console.size(), ref_q.size());
        for (int i = 0; i < mem_model.console.size(); i++) begin
            assert (mem_model.console[i] != 8'hEE)
            else begin
                errors++;
                $display("a skipped marker byte reached the console at entry %0d", i);
            end
            if (i < ref_q.size()) check_hex("console byte", mem_model.console[i], ref_q[i]);
        end
    endtask

    initial begin
        void'($urandom(20));
        clk      = 1'b0;
        rst_n    = 1'b0;
        rdy      = 1'b1;
        pause_en = 1'b0;
        clear    = 1'b1;
        errors   = 0;
        build_program();
        run_program(1'b0);
        check_console(expected);
        first_run = mem_model.console;
        run_program(1'b1);
        check_console(first_run);
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/tb_memory.sv
`timescale 1ns/1ps

module tb_memory
    import rv_pkg::*;
(
    input  logic        clk_i,
    input  logic        clear_i,   // empties the console and drops stop
    input  logic        mem_wr_i,
    input  logic [31:0] mem_a_i,
    input  logic [7:0]  wdata_i,
    output logic [7:0]  rdata_o,
    output logic        stop_o
);

    logic [7:0] mem [131072];  // 128 KB
    logic [7:0] console [$];   // nonzero bytes written to the console port

    initial rdata_o = 8'h00;

    // registered read, so the byte follows its address by one cycle
    always @(posedge clk_i) begin
        rdata_o <= mem[mem_a_i[16:0]];
        if (clear_i) begin
            console.delete();
            stop_o <= 1'b0;
        end else if (mem_wr_i) begin
            if (mem_a_i == IO_BASE) begin
                if (wdata_i != 8'h00) console.push_back(wdata_i);
            end else if (mem_a_i == IO_STOP) begin
                stop_o <= 1'b1;
            end else if (mem_a_i < 32'h0002_0000) begin
                mem[mem_a_i[16:0]] <= wdata_i;
            end
        end
    end

endmodule

// File: verilog.f
design/rv_pkg.sv
design/mem_ctrl.sv
design/fetch_unit.sv
design/exec_unit.sv
design/retire_unit.sv
design/reg_file.sv
design/cpu.sv
verif/tb_memory.sv
verif/tb_cpu.sv
